/* vlog.f */
sa_pkg.sv
sa_index_counter.sv
sa_ctrl_fsm.sv
sa_matrix_store.sv
sa_dot_unit.sv
sa_top.sv
sa_properties.sv
tb_sa.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_sa
FILELIST  := vlog.f
VFLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* tb_sa.sv */
/*
 * Testbench for the attention engine: clock and reset, matrix stream
 * stimulus, reference model, output comparison and cycle timeout
 */
`default_nettype none

module tb_sa;

    localparam int NUM_RUNS   = 8;
    localparam int LIMIT      = 450 * NUM_RUNS + 20;
    localparam int STREAM_LEN = 192;

    logic                              clk;
    logic                              rst_n;
    logic                              in_valid;
    logic [sa_pkg::T_W-1:0]            t;
    logic signed [sa_pkg::DATA_W-1:0]  in_data;
    logic signed [sa_pkg::DATA_W-1:0]  w_q;
    logic signed [sa_pkg::DATA_W-1:0]  w_k;
    logic signed [sa_pkg::DATA_W-1:0]  w_v;
    logic                              out_valid;
    logic signed [sa_pkg::ACC_W-1:0]   out_data;

    integer seed;
    int     cycles;
    logic   in_burst;

    // Matrices of the current run, weights indexed 0 = Q, 1 = K, 2 = V
    int x_m [sa_pkg::DIM][sa_pkg::DIM];
    int w_m [3][sa_pkg::DIM][sa_pkg::DIM];

    longint expected_q [$];

    sa_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .t         (t),
        .in_data   (in_data),
        .w_q       (w_q),
        .w_k       (w_k),
        .w_v       (w_v),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #50 clk = ~clk;

    function automatic int rand_elem();
        int r;
        logic signed [7:0] b;
        r = $random(seed);
        b = r[7:0];
        return int'(b);
    endfunction

    // Symmetric range so that the negated value still fits in int8
    function automatic int rand_sym();
        int r;
        r = $random(seed);
        return r % 128;
    endfunction

    // Rows at or beyond T do not take part
    function automatic int x_val(input int r, input int c, input int tv);
        return (r < tv) ? x_m[r][c] : 0;
    endfunction

    function automatic longint project(input int sel, input int r, input int c, input int tv);
        longint acc;
        acc = 0;
        for (int i = 0; i < sa_pkg::DIM; i++) begin
            acc += longint'(x_val(r, i, tv)) * longint'(w_m[sel][i][c]);
        end
        return acc;
    endfunction

    // Output word (i, k) of S.V with S clamped at zero and divided by 3
    function automatic longint expected_word(input int tv, input int i, input int k);
        longint acc;
        longint qk;
        longint s;
        acc = 0;
        for (int j = 0; j < tv; j++) begin
            qk = 0;
            for (int m = 0; m < sa_pkg::DIM; m++) begin
                qk += project(0, i, m, tv) * project(1, j, m, tv);
            end
            s = (qk < 0) ? 64'sd0 : qk / 3;
            acc += s * project(2, j, k, tv);
        end
        return acc;
    endfunction

    task automatic check_data(input logic signed [sa_pkg::ACC_W-1:0] got,
                              input logic signed [sa_pkg::ACC_W-1:0] expected);
        if (got !== expected) begin
            $display("error time=%0t signal=out_data got=%0d expected=%0d",
                     $time, got, expected);
            $display("RESULT: FAIL");
            $fatal(1, "out_data mismatch");
        end
    endtask

    task automatic check_valid(input logic got, input logic expected);
        if (got !== expected) begin
            $display("error time=%0t signal=out_valid got=%b expected=%b",
                     $time, got, expected);
            $display("RESULT: FAIL");
            $fatal(1, "out_valid mismatch");
        end
    endtask

    task automatic fill_matrices(input logic neg_keys);
        for (int r = 0; r < sa_pkg::DIM; r++) begin
            for (int c = 0; c < sa_pkg::DIM; c++) begin
                // No zeros, so unused X rows always carry garbage
                x_m[r][c] = rand_elem();
                if (x_m[r][c] == 0) begin
                    x_m[r][c] = 77;
                end
                if (neg_keys) begin
                    w_m[0][r][c] = rand_sym();
                    w_m[1][r][c] = -w_m[0][r][c];
                end else begin
                    w_m[0][r][c] = rand_elem();
                    w_m[1][r][c] = rand_elem();
                end
                w_m[2][r][c] = rand_elem();
            end
        end
    endtask

    task automatic run_attention(input logic [sa_pkg::T_W-1:0] t_val);
        int tv;
        int r;
        int c;
        tv = int'(t_val);
        for (int i = 0; i < tv; i++) begin
            for (int k = 0; k < sa_pkg::DIM; k++) begin
                expected_q.push_back(expected_word(tv, i, k));
            end
        end
        for (int n = 0; n < STREAM_LEN; n++) begin
            @(posedge clk);
            #10;
            r = (n % 64) / 8;
            c = n % 8;
            in_valid = 1'b1;
            t        = (n == 0) ? t_val : 4'(rand_elem());
            in_data  = (n < 64) ? 8'(x_m[r][c]) : 8'(rand_elem());
            w_q      = (n < 64) ? 8'(w_m[0][r][c]) : 8'(rand_elem());
            w_k      = (n >= 64 && n < 128) ? 8'(w_m[1][r][c]) : 8'(rand_elem());
            w_v      = (n >= 128) ? 8'(w_m[2][r][c]) : 8'(rand_elem());
        end
        @(posedge clk);
        #10;
        in_valid = 1'b0;
        // Run is over once every word arrived and out_valid fell
        do begin
            @(posedge clk);
            #10;
        end while (expected_q.size() != 0 || out_valid);
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid && expected_q.size() != 0) begin
                check_data(out_data, expected_q.pop_front());
                in_burst = (expected_q.size() != 0);
            end else begin
                // Valid stays high for the whole burst and never outside it
                check_valid(out_valid, in_burst);
                check_data(out_data, 64'sd0);
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: out_valid never finished within %0d cycles", LIMIT);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        seed        = 13309;
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        t           = '0;
        in_data     = '0;
        w_q         = '0;
        w_k         = '0;
        w_v         = '0;
        cycles      = 0;
        in_burst    = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;

        fill_matrices(1'b0);
        run_attention(4'd8);
        fill_matrices(1'b0);
        run_attention(4'd1);
        fill_matrices(1'b0);
        run_attention(4'd3);
        // X rows 4 to 7 hold garbage here
        fill_matrices(1'b0);
        run_attention(4'd4);
        // WK = -WQ, many negative scores
        fill_matrices(1'b1);
        run_attention(4'd8);
        fill_matrices(1'b1);
        run_attention(4'd5);
        fill_matrices(1'b0);
        run_attention(4'd2);
        fill_matrices(1'b0);
        run_attention(4'd7);

        // Idle tail to catch late valid pulses
        repeat (20) @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sa_properties.sv */
/*
 * Concurrent checks on the output controls of sa_top, attached by bind
 */
`default_nettype none

module sa_properties (
    input  logic                            clk,
    input  logic                            rst_n,
    input  sa_pkg::sa_state_e               state,
    input  logic                            out_valid,
    input  logic signed [sa_pkg::ACC_W-1:0] out_data
);

    // Output idle right after reset release
    valid_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !out_valid
    ) else $error("out_valid high in the first cycle after reset");

    data_zero_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        !out_valid |-> (out_data == '0)
    ) else $error("out_data nonzero while out_valid is low");

    // Registered valid follows the output state by one cycle
    valid_only_from_out: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(out_valid) |-> ($past(state) == sa_pkg::ST_OUT)
    ) else $error("out_valid rose outside the output state");

endmodule

bind sa_top sa_properties u_properties (
    .clk       (clk),
    .rst_n     (rst_n),
    .state     (state),
    .out_valid (out_valid),
    .out_data  (out_data)
);

`default_nettype wire

/* sa_top.sv */
/*
 * Top level of the attention engine: input register, T capture,
 * output registers and the control and datapath instances
 */
`default_nettype none

module sa_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              in_valid,
    input  logic [sa_pkg::T_W-1:0]            t,
    input  logic signed [sa_pkg::DATA_W-1:0]  in_data,
    input  logic signed [sa_pkg::DATA_W-1:0]  w_q,
    input  logic signed [sa_pkg::DATA_W-1:0]  w_k,
    input  logic signed [sa_pkg::DATA_W-1:0]  w_v,
    output logic                              out_valid,
    output logic signed [sa_pkg::ACC_W-1:0]   out_data
);

    sa_pkg::sa_state_e                 state;
    sa_pkg::sa_index_u                 idx;
    sa_pkg::sa_index_u                 idx_d1;
    logic                              load_last;
    logic                              score_last;
    logic                              out_last;
    sa_pkg::sa_in_s                    sample;
    logic [sa_pkg::T_W-1:0]            t_q;
    sa_pkg::sa_opa_t                   opa;
    sa_pkg::sa_opb_t                   opb;
    logic signed [sa_pkg::ACC_W-1:0]   dot;
    logic signed [sa_pkg::SCORE_W-1:0] score;

    // Stream cycle n lands in the store on load step n
    always_ff @(posedge clk) begin
        sample <= '{data: in_data, w_q: w_q, w_k: w_k, w_v: w_v};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            t_q       <= '0;
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            if (state == sa_pkg::ST_IDLE) begin
                t_q <= t;
            end
            out_valid <= (state == sa_pkg::ST_OUT);
            out_data  <= (state == sa_pkg::ST_OUT) ? dot : '0;
        end
    end

    sa_ctrl_fsm u_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .load_last  (load_last),
        .score_last (score_last),
        .out_last   (out_last),
        .state      (state)
    );

    sa_index_counter u_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .t          (t_q),
        .idx        (idx),
        .idx_d1     (idx_d1),
        .load_last  (load_last),
        .score_last (score_last),
        .out_last   (out_last)
    );

    sa_matrix_store u_store (
        .clk    (clk),
        .rst_n  (rst_n),
        .state  (state),
        .idx    (idx),
        .idx_d1 (idx_d1),
        .t      (t_q),
        .sample (sample),
        .dot    (dot),
        .score  (score),
        .opa    (opa),
        .opb    (opb)
    );

    sa_dot_unit u_dot (
        .clk   (clk),
        .rst_n (rst_n),
        .opa   (opa),
        .opb   (opb),
        .dot   (dot),
        .score (score)
    );

endmodule

`default_nettype wire

/* sa_dot_unit.sv */
/*
 * Shared 8-lane dot product with a three-level adder tree,
 * the registered sum and the clamp-and-divide score path
 */
`default_nettype none

module sa_dot_unit (
    input  logic                               clk,
    input  logic                               rst_n,
    input  sa_pkg::sa_opa_t                    opa,
    input  sa_pkg::sa_opb_t                    opb,
    output logic signed [sa_pkg::ACC_W-1:0]    dot,
    output logic signed [sa_pkg::SCORE_W-1:0]  score
);

    logic signed [sa_pkg::ACC_W-1:0] prod   [sa_pkg::DIM];
    logic signed [sa_pkg::ACC_W-1:0] sum_l1 [sa_pkg::DIM/2];
    logic signed [sa_pkg::ACC_W-1:0] sum_l2 [sa_pkg::DIM/4];
    logic signed [sa_pkg::ACC_W-1:0] sum_q;
    logic        [sa_pkg::ACC_W-1:0] relu;
    logic        [sa_pkg::ACC_W-1:0] quot;

    always_comb begin
        for (int i = 0; i < sa_pkg::DIM; i++) begin
            prod[i] = $signed(opa[i]) * $signed(opb[i]);
        end
        for (int i = 0; i < sa_pkg::DIM/2; i++) begin
            sum_l1[i] = prod[2*i] + prod[2*i+1];
        end
        for (int i = 0; i < sa_pkg::DIM/4; i++) begin
            sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
        end
        dot = sum_l2[0] + sum_l2[1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_q <= '0;
        end else begin
            sum_q <= dot;
        end
    end

    // Negative scores clamp to zero, then truncating divide
    assign relu  = sum_q[sa_pkg::ACC_W-1] ? '0 : sum_q;
    assign quot  = relu / sa_pkg::SCORE_DIV;
    assign score = quot[sa_pkg::SCORE_W-1:0];

endmodule

`default_nettype wire

/* sa_matrix_store.sv */
/*
 * Matrix storage for X/S, the weights and Q, K, V, with write
 * selection per load phase and dot-operand row and column selection
 */
`default_nettype none

module sa_matrix_store (
    input  logic                               clk,
    input  logic                               rst_n,
    input  sa_pkg::sa_state_e                  state,
    input  sa_pkg::sa_index_u                  idx,
    input  sa_pkg::sa_index_u                  idx_d1,
    input  logic [sa_pkg::T_W-1:0]             t,
    input  sa_pkg::sa_in_s                     sample,
    input  logic signed [sa_pkg::ACC_W-1:0]    dot,
    input  logic signed [sa_pkg::SCORE_W-1:0]  score,
    output sa_pkg::sa_opa_t                    opa,
    output sa_pkg::sa_opb_t                    opb
);

    // X, later S
    logic signed [sa_pkg::SCORE_W-1:0] xs [sa_pkg::DIM][sa_pkg::DIM];
    // WQ, later WV
    logic signed [sa_pkg::PROJ_W-1:0]  w  [sa_pkg::DIM][sa_pkg::DIM];
    // WK, later V
    logic signed [sa_pkg::PROJ_W-1:0]  wk [sa_pkg::DIM][sa_pkg::DIM];
    logic signed [sa_pkg::PROJ_W-1:0]  q  [sa_pkg::DIM][sa_pkg::DIM];
    logic signed [sa_pkg::PROJ_W-1:0]  k  [sa_pkg::DIM][sa_pkg::DIM];

    logic [sa_pkg::DIM_W-1:0]          row;
    logic [sa_pkg::DIM_W-1:0]          col;
    logic                              keep_row;
    logic signed [sa_pkg::SCORE_W-1:0] x_ext;
    logic signed [sa_pkg::PROJ_W-1:0]  wq_ext;
    logic signed [sa_pkg::PROJ_W-1:0]  wk_ext;
    logic signed [sa_pkg::PROJ_W-1:0]  wv_ext;
    logic signed [sa_pkg::PROJ_W-1:0]  proj;

    function automatic logic signed [sa_pkg::SCORE_W-1:0] to_score(
        input logic signed [sa_pkg::PROJ_W-1:0] v
    );
        return {{(sa_pkg::SCORE_W - sa_pkg::PROJ_W){v[sa_pkg::PROJ_W-1]}}, v};
    endfunction

    assign row      = idx.pos.row;
    assign col      = idx.pos.col;
    assign keep_row = {1'b0, row} < t;

    assign x_ext  = {{(sa_pkg::SCORE_W - sa_pkg::DATA_W){sample.data[sa_pkg::DATA_W-1]}},
                     sample.data};
    assign wq_ext = {{(sa_pkg::PROJ_W - sa_pkg::DATA_W){sample.w_q[sa_pkg::DATA_W-1]}},
                     sample.w_q};
    assign wk_ext = {{(sa_pkg::PROJ_W - sa_pkg::DATA_W){sample.w_k[sa_pkg::DATA_W-1]}},
                     sample.w_k};
    assign wv_ext = {{(sa_pkg::PROJ_W - sa_pkg::DATA_W){sample.w_v[sa_pkg::DATA_W-1]}},
                     sample.w_v};
    assign proj   = dot[sa_pkg::PROJ_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < sa_pkg::DIM; r++) begin
                for (int c = 0; c < sa_pkg::DIM; c++) begin
                    xs[r][c] <= '0;
                    w[r][c]  <= '0;
                    wk[r][c] <= '0;
                    q[r][c]  <= '0;
                    k[r][c]  <= '0;
                end
            end
        end else if (state == sa_pkg::ST_IDLE) begin
            for (int r = 0; r < sa_pkg::DIM; r++) begin
                for (int c = 0; c < sa_pkg::DIM; c++) begin
                    xs[r][c] <= '0;
                    w[r][c]  <= '0;
                    wk[r][c] <= '0;
                    q[r][c]  <= '0;
                    k[r][c]  <= '0;
                end
            end
        end else if (state == sa_pkg::ST_LOAD) begin
            // Projection of the previous matrix overlaps the next load
            case (idx.pos.phase)
                2'd0: begin
                    xs[row][col] <= keep_row ? x_ext : '0;
                    w[row][col]  <= wq_ext;
                end
                2'd1: begin
                    wk[row][col] <= wk_ext;
                    q[row][col]  <= proj;
                end
                2'd2: begin
                    w[row][col] <= wv_ext;
                    k[row][col] <= proj;
                end
                default: begin
                    wk[row][col] <= proj;
                end
            endcase
        end else if (state == sa_pkg::ST_SCORE && idx_d1.pos.phase == 2'd0) begin
            // One cycle behind the multiply
            xs[idx_d1.pos.row][idx_d1.pos.col] <= score;
        end
    end

    always_comb begin
        opa = '0;
        opb = '0;
        for (int i = 0; i < sa_pkg::DIM; i++) begin
            case (state)
                sa_pkg::ST_LOAD: begin
                    if (idx.pos.phase != 2'd0) begin
                        opa[i] = xs[row][i];
                        opb[i] = (idx.pos.phase == 2'd2) ? wk[i][col] : w[i][col];
                    end
                end
                sa_pkg::ST_SCORE: begin
                    opa[i] = to_score(q[row][i]);
                    opb[i] = k[col][i];
                end
                sa_pkg::ST_OUT: begin
                    opa[i] = xs[row][i];
                    opb[i] = wk[i][col];
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* sa_ctrl_fsm.sv */
/*
 * Run sequencer: idle, load, score and output phases
 */
`default_nettype none

module sa_ctrl_fsm (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic              load_last,
    input  logic              score_last,
    input  logic              out_last,
    output sa_pkg::sa_state_e state
);

    sa_pkg::sa_state_e state_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= sa_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            sa_pkg::ST_IDLE: begin
                if (in_valid) begin
                    state_next = sa_pkg::ST_LOAD;
                end
            end
            sa_pkg::ST_LOAD: begin
                if (load_last) begin
                    state_next = sa_pkg::ST_SCORE;
                end
            end
            sa_pkg::ST_SCORE: begin
                // Includes one drain cycle for the last score write
                if (score_last) begin
                    state_next = sa_pkg::ST_OUT;
                end
            end
            default: begin
                if (out_last) begin
                    state_next = sa_pkg::ST_IDLE;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* sa_index_counter.sv */
/*
 * Step counter for the attention engine: linear count in load and
 * output, bounded row/column walk in score, end flags per state
 */
`default_nettype none

module sa_index_counter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  sa_pkg::sa_state_e      state,
    input  logic [sa_pkg::T_W-1:0] t,
    output sa_pkg::sa_index_u      idx,
    output sa_pkg::sa_index_u      idx_d1,
    output logic                   load_last,
    output logic                   score_last,
    output logic                   out_last
);

    logic [sa_pkg::T_W-1:0] t_dec;
    logic                   col_end;
    logic                   row_end;
    sa_pkg::sa_index_u      idx_next;

    assign t_dec   = t - 1'b1;
    assign col_end = {1'b0, idx.pos.col} == t_dec;
    assign row_end = {1'b0, idx.pos.row} == t_dec;

    always_comb begin
        idx_next = idx;
        case (state)
            sa_pkg::ST_LOAD, sa_pkg::ST_OUT: begin
                idx_next.raw = idx.raw + 1'b1;
            end
            sa_pkg::ST_SCORE: begin
                // Non-zero phase means the T x T walk is done
                if (idx.pos.phase != 2'd0) begin
                    idx_next.raw = '0;
                end else if (!col_end) begin
                    idx_next.pos.col = idx.pos.col + 1'b1;
                end else begin
                    idx_next.pos.col = '0;
                    if (row_end) begin
                        idx_next.pos.row   = '0;
                        idx_next.pos.phase = idx.pos.phase + 1'b1;
                    end else begin
                        idx_next.pos.row = idx.pos.row + 1'b1;
                    end
                end
            end
            default: begin
                idx_next.raw = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx    <= '0;
            idx_d1 <= '0;
        end else begin
            idx    <= idx_next;
            idx_d1 <= idx;
        end
    end

    assign load_last  = (state == sa_pkg::ST_LOAD) && (idx.raw == '1);
    assign score_last = (state == sa_pkg::ST_SCORE) && (idx.pos.phase == 2'd1) &&
                        (idx.pos.row == '0) && (idx.pos.col == '0);
    assign out_last   = (state == sa_pkg::ST_OUT) && row_end && (idx.pos.col == '1);

endmodule

`default_nettype wire

/* sa_pkg.sv */
/*
 * Shared definitions for the single-head attention engine:
 * geometry and width constants, FSM states, the step index union,
 * the registered input sample and the dot-product operand vectors
 */
`default_nettype none

package sa_pkg;

    // Geometry
    localparam int DIM   = 8;
    localparam int DIM_W = 3;
    localparam int T_W   = 4;

    // Element widths
    localparam int DATA_W  = 8;
    localparam int PROJ_W  = 19;
    localparam int SCORE_W = 41;
    localparam int ACC_W   = 64;

    localparam int SCORE_DIV = 3;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_SCORE,
        ST_OUT
    } sa_state_e;

    typedef struct packed {
        logic [1:0]       phase;
        logic [DIM_W-1:0] row;
        logic [DIM_W-1:0] col;
    } sa_idx_s;

    // Linear count in load and output, phase/row/col for addressing
    typedef union packed {
        logic [2*DIM_W+1:0] raw;
        sa_idx_s            pos;
    } sa_index_u;

    typedef struct packed {
        logic signed [DATA_W-1:0] data;
        logic signed [DATA_W-1:0] w_q;
        logic signed [DATA_W-1:0] w_k;
        logic signed [DATA_W-1:0] w_v;
    } sa_in_s;

    typedef logic [DIM-1:0][SCORE_W-1:0] sa_opa_t;
    typedef logic [DIM-1:0][PROJ_W-1:0]  sa_opb_t;

endpackage

`default_nettype wire
